// ==== matmul_defs.svh ====
`ifndef MATMUL_DEFS_SVH
`define MATMUL_DEFS_SVH

// element width
`define MM_DWIDTH 16
// memory address width and depth
`define MM_AWIDTH 7
`define MM_MEM_SIZE 128

// matrix order, also the lane count of a memory row
`define MM_SIZE 4
// diagonals of the result, 2*size-1
`define MM_DIAGS 7

// engine address to memory data
`define MM_READ_LATENCY 2
// cycles after the last feed until every cell has settled
`define MM_DRAIN_CYCLES 10

`endif

// ==== matmul_pkg.sv ====
`include "matmul_defs.svh"

package matmul_pkg;

  // one matrix element
  typedef logic [`MM_DWIDTH-1:0] data_t;
  // full width accumulator
  typedef logic [2*`MM_DWIDTH-1:0] acc_t;
  // memory address
  typedef logic [`MM_AWIDTH-1:0] addr_t;
  // one memory word, lane 0 in the low bits
  typedef logic [`MM_SIZE*`MM_DWIDTH-1:0] row_t;

  // run phases of the sequencer
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_CLEAR,
    SEQ_FEED,
    SEQ_DRAIN,
    SEQ_WRITE,
    SEQ_DONE
  } seq_state_t;

endpackage

// ==== matrix_bank.sv ====
`timescale 1ns/10ps
`include "matmul_defs.svh"

module matrix_bank import matmul_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  host_sel,
  input  addr_t host_addr,
  input  addr_t eng_addr,
  input  logic  we,
  input  row_t  wdata,
  output row_t  rdata
);

  addr_t addr_next;
  addr_t addr_q;
  logic  we_q;
  row_t  wdata_q;
  row_t  mem [`MM_MEM_SIZE];

  // host owns the port while its select is up
  assign addr_next = host_sel ? host_addr : eng_addr;

  // address and strobe move together into the register stage
  always_ff @(posedge clk) begin
    if (reset) begin
      addr_q <= '0;
      we_q   <= 1'b0;
    end else begin
      addr_q <= addr_next;
      we_q   <= we;
    end
  end

  // write word follows its address
  always_ff @(posedge clk) begin
    wdata_q <= wdata;
  end

  // single port array, registered read
  always_ff @(posedge clk) begin
    if (we_q) begin
      mem[addr_q] <= wdata_q;
    end
    rdata <= mem[addr_q];
  end

  // a strobe one cycle ahead must come with a known address
  no_write_to_unknown: assert property (
    @(posedge clk) disable iff (reset) we |-> !$isunknown(addr_next)
  ) else $error("matrix_bank write with unknown address");

endmodule

// ==== step_counter.sv ====
`timescale 1ns/10ps

module step_counter #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             load,
  input  logic [WIDTH-1:0] limit,
  input  logic             step,
  output logic [WIDTH-1:0] count,
  output logic             last
);

  logic [WIDTH-1:0] limit_q;

  // load restarts at zero and wins over step
  always_ff @(posedge clk) begin
    if (reset) begin
      count   <= '0;
      limit_q <= '0;
    end else if (load) begin
      count   <= '0;
      limit_q <= limit;
    end else if (step) begin
      count <= count + 1'b1;
    end
  end

  // final step of the phase
  assign last = (count == limit_q);

  // the owner has to reload on last, otherwise the count runs past
  count_in_range: assert property (
    @(posedge clk) disable iff (reset) count <= limit_q
  ) else $error("step_counter passed its limit");

endmodule

// ==== matmul_sequencer.sv ====
`timescale 1ns/10ps
`include "matmul_defs.svh"

module matmul_sequencer import matmul_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  start_mat_mul,
  output logic  done_mat_mul,
  output logic  acc_clear,
  output addr_t eng_addr,
  output logic  skew_valid,
  output addr_t diag_index,
  output logic  diag_write
);

  seq_state_t state;
  seq_state_t next_state;
  logic       cnt_load;
  logic       cnt_step;
  logic       cnt_last;
  addr_t      cnt_limit;
  addr_t      count;
  logic       feed_valid;
  logic [`MM_READ_LATENCY-1:0] valid_pipe;

  // shared phase counter, its count is the feed address or the diagonal
  step_counter #(
    .WIDTH(`MM_AWIDTH)
  ) u_step (
    .clk   (clk),
    .reset (reset),
    .load  (cnt_load),
    .limit (cnt_limit),
    .step  (cnt_step),
    .count (count),
    .last  (cnt_last)
  );

  always_comb begin
    next_state = state;
    cnt_load   = 1'b0;
    cnt_limit  = '0;
    case (state)
      SEQ_IDLE: begin
        // one cycle of accumulator clear
        if (start_mat_mul) begin
          next_state = SEQ_CLEAR;
          cnt_load   = 1'b1;
        end
      end
      SEQ_CLEAR: begin
        if (cnt_last) begin
          next_state = SEQ_FEED;
          cnt_load   = 1'b1;
          cnt_limit  = addr_t'(`MM_SIZE - 1);
        end
      end
      SEQ_FEED: begin
        if (cnt_last) begin
          next_state = SEQ_DRAIN;
          cnt_load   = 1'b1;
          cnt_limit  = addr_t'(`MM_DRAIN_CYCLES - 1);
        end
      end
      SEQ_DRAIN: begin
        if (cnt_last) begin
          next_state = SEQ_WRITE;
          cnt_load   = 1'b1;
          cnt_limit  = addr_t'(`MM_DIAGS - 1);
        end
      end
      SEQ_WRITE: begin
        // park the counter at zero for the done phase
        if (cnt_last) begin
          next_state = SEQ_DONE;
          cnt_load   = 1'b1;
        end
      end
      SEQ_DONE: begin
        next_state = SEQ_DONE;
      end
      default: begin
        next_state = SEQ_IDLE;
      end
    endcase
    // start is a level, dropping it ends the run from any phase
    if (!start_mat_mul) begin
      next_state = SEQ_IDLE;
    end
  end

  // counter advances only in the timed phases
  assign cnt_step = (state == SEQ_FEED) || (state == SEQ_DRAIN) || (state == SEQ_WRITE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= SEQ_IDLE;
      done_mat_mul <= 1'b0;
      valid_pipe   <= '0;
    end else begin
      state        <= next_state;
      done_mat_mul <= (next_state == SEQ_DONE);
      // valid waits out the memory read latency
      valid_pipe   <= {valid_pipe[`MM_READ_LATENCY-2:0], feed_valid};
    end
  end

  assign feed_valid = (state == SEQ_FEED);
  assign skew_valid = valid_pipe[`MM_READ_LATENCY-1];
  assign acc_clear  = (state == SEQ_CLEAR);

  // addresses parked at zero outside their phase
  assign eng_addr   = feed_valid ? count : '0;
  assign diag_write = (state == SEQ_WRITE);
  assign diag_index = diag_write ? count : '0;

  // done rises only once the last diagonal has gone out
  done_after_last_diag: assert property (
    @(posedge clk) disable iff (reset)
      $rose(done_mat_mul) |->
        $past(diag_write) && $past(diag_index) == addr_t'(`MM_DIAGS - 1)
  ) else $error("done_mat_mul rose before the last diagonal");

endmodule

// ==== operand_skew.sv ====
`timescale 1ns/10ps
`include "matmul_defs.svh"

module operand_skew import matmul_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic clear,
  input  logic valid,
  input  row_t row,
  output row_t lanes
);

  row_t gated;

  // zeros outside the feed window
  assign gated = valid ? row : '0;

  for (genvar i = 0; i < `MM_SIZE; i++) begin : g_lane
    if (i == 0) begin : g_direct
      // lane 0 enters the grid without delay
      assign lanes[0 +: `MM_DWIDTH] = gated[0 +: `MM_DWIDTH];
    end else begin : g_delay
      // lane i gets i register stages
      data_t stage [i];

      always_ff @(posedge clk) begin
        if (reset || clear) begin
          for (int d = 0; d < i; d++) begin
            stage[d] <= '0;
          end
        end else begin
          stage[0] <= gated[i*`MM_DWIDTH +: `MM_DWIDTH];
          for (int d = 1; d < i; d++) begin
            stage[d] <= stage[d-1];
          end
        end
      end

      assign lanes[i*`MM_DWIDTH +: `MM_DWIDTH] = stage[i-1];
    end
  end

endmodule

// ==== processing_element.sv ====
`timescale 1ns/10ps

module processing_element import matmul_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  clear,
  input  data_t in_a,
  input  data_t in_b,
  output data_t out_a,
  output data_t out_b,
  output acc_t  acc
);

  acc_t product;

  // unsigned 16x16 into the full accumulator width
  assign product = acc_t'(in_a) * acc_t'(in_b);

  // sum wraps modulo 2^32, cleared at every run start
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      acc <= '0;
    end else begin
      acc <= acc + product;
    end
  end

  // operands hop one cell per cycle
  always_ff @(posedge clk) begin
    out_a <= in_a;
    out_b <= in_b;
  end

endmodule

// ==== systolic_array.sv ====
`timescale 1ns/10ps
`include "matmul_defs.svh"

module systolic_array import matmul_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic clear,
  input  row_t a_lanes,
  input  row_t b_lanes,
  output acc_t [`MM_SIZE*`MM_SIZE-1:0] results
);

  // a moves right along a row, b moves down a column
  data_t a_link [`MM_SIZE][`MM_SIZE+1];
  data_t b_link [`MM_SIZE+1][`MM_SIZE];

  for (genvar i = 0; i < `MM_SIZE; i++) begin : g_edge
    // a lane i feeds row i, b lane i feeds column i
    assign a_link[i][0] = a_lanes[i*`MM_DWIDTH +: `MM_DWIDTH];
    assign b_link[0][i] = b_lanes[i*`MM_DWIDTH +: `MM_DWIDTH];
  end

  for (genvar r = 0; r < `MM_SIZE; r++) begin : g_row
    for (genvar c = 0; c < `MM_SIZE; c++) begin : g_col
      // cell (r,c) builds C[r][c]
      processing_element u_pe (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .in_a  (a_link[r][c]),
        .in_b  (b_link[r][c]),
        .out_a (a_link[r][c+1]),
        .out_b (b_link[r+1][c]),
        .acc   (results[r*`MM_SIZE+c])
      );
    end
  end

endmodule

// ==== result_packer.sv ====
`timescale 1ns/10ps
`include "matmul_defs.svh"

module result_packer import matmul_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  acc_t [`MM_SIZE*`MM_SIZE-1:0] results,
  input  addr_t diag_index,
  input  logic  diag_write,
  output addr_t c_addr,
  output row_t  c_data,
  output logic  c_we
);

  data_t sat [`MM_SIZE*`MM_SIZE];
  row_t  diag_row;

  // any bit in the upper half pins the element to all ones
  always_comb begin
    for (int k = 0; k < `MM_SIZE*`MM_SIZE; k++) begin
      if (|results[k][2*`MM_DWIDTH-1:`MM_DWIDTH]) begin
        sat[k] = '1;
      end else begin
        sat[k] = results[k][`MM_DWIDTH-1:0];
      end
    end
  end

  // lane i of diagonal k is C[i][k-i]
  always_comb begin
    int col;
    diag_row = '0;
    for (int i = 0; i < `MM_SIZE; i++) begin
      col = int'(diag_index) - i;
      // lanes off the matrix stay zero
      if (col >= 0 && col < `MM_SIZE) begin
        diag_row[i*`MM_DWIDTH +: `MM_DWIDTH] = sat[i*`MM_SIZE + col];
      end
    end
  end

  // write lands one cycle after diag_write
  always_ff @(posedge clk) begin
    if (reset) begin
      c_addr <= '0;
      c_we   <= 1'b0;
    end else begin
      c_addr <= diag_index;
      c_we   <= diag_write;
    end
  end

  always_ff @(posedge clk) begin
    c_data <= diag_row;
  end

endmodule

// ==== matmul_top.sv ====
`timescale 1ns/10ps
`include "matmul_defs.svh"

module matmul_top import matmul_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  enable_writing_to_mem,
  input  logic  enable_reading_from_mem,
  input  row_t  data_pi,
  input  addr_t addr_pi,
  input  logic  we_a,
  input  logic  we_b,
  output row_t  data_from_out_mat,
  input  logic  start_mat_mul,
  output logic  done_mat_mul
);

  addr_t eng_addr;
  row_t  a_data;
  row_t  b_data;
  logic  acc_clear;
  logic  skew_valid;
  row_t  a_lanes;
  row_t  b_lanes;
  acc_t [`MM_SIZE*`MM_SIZE-1:0] results;
  addr_t diag_index;
  logic  diag_write;
  addr_t c_addr;
  row_t  c_data;
  logic  c_we;

  // A holds columns of A, one per address
  matrix_bank u_bank_a (
    .clk       (clk),
    .reset     (reset),
    .host_sel  (enable_writing_to_mem),
    .host_addr (addr_pi),
    .eng_addr  (eng_addr),
    .we        (we_a),
    .wdata     (data_pi),
    .rdata     (a_data)
  );

  // B holds rows of B, same engine address as A
  matrix_bank u_bank_b (
    .clk       (clk),
    .reset     (reset),
    .host_sel  (enable_writing_to_mem),
    .host_addr (addr_pi),
    .eng_addr  (eng_addr),
    .we        (we_b),
    .wdata     (data_pi),
    .rdata     (b_data)
  );

  // C written by the engine, read back by the host
  matrix_bank u_bank_c (
    .clk       (clk),
    .reset     (reset),
    .host_sel  (enable_reading_from_mem),
    .host_addr (addr_pi),
    .eng_addr  (c_addr),
    .we        (c_we),
    .wdata     (c_data),
    .rdata     (data_from_out_mat)
  );

  matmul_sequencer u_seq (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .done_mat_mul  (done_mat_mul),
    .acc_clear     (acc_clear),
    .eng_addr      (eng_addr),
    .skew_valid    (skew_valid),
    .diag_index    (diag_index),
    .diag_write    (diag_write)
  );

  // staircase on both operand edges
  operand_skew u_skew_a (
    .clk   (clk),
    .reset (reset),
    .clear (acc_clear),
    .valid (skew_valid),
    .row   (a_data),
    .lanes (a_lanes)
  );

  operand_skew u_skew_b (
    .clk   (clk),
    .reset (reset),
    .clear (acc_clear),
    .valid (skew_valid),
    .row   (b_data),
    .lanes (b_lanes)
  );

  systolic_array u_array (
    .clk     (clk),
    .reset   (reset),
    .clear   (acc_clear),
    .a_lanes (a_lanes),
    .b_lanes (b_lanes),
    .results (results)
  );

  result_packer u_pack (
    .clk        (clk),
    .reset      (reset),
    .results    (results),
    .diag_index (diag_index),
    .diag_write (diag_write),
    .c_addr     (c_addr),
    .c_data     (c_data),
    .c_we       (c_we)
  );

endmodule

// ==== tb_matmul.sv ====
`timescale 1ns/10ps
`include "matmul_defs.svh"

module tb_matmul import matmul_pkg::*; ();

  localparam int RUNS = 8;
  // about 60 cycles per run, generous margin
  localparam int TIMEOUT_CYCLES = RUNS * 200;
  localparam int HOLD_CYCLES = 4;

  logic  clk;
  logic  reset;
  logic  enable_writing_to_mem;
  logic  enable_reading_from_mem;
  row_t  data_pi;
  addr_t addr_pi;
  logic  we_a;
  logic  we_b;
  row_t  data_from_out_mat;
  logic  start_mat_mul;
  logic  done_mat_mul;

  integer seed = 32'h62b51fbd;
  int     cycle_count;
  int     sat_seen;
  int     exact_seen;
  data_t  a_mat [`MM_SIZE][`MM_SIZE];
  data_t  b_mat [`MM_SIZE][`MM_SIZE];
  row_t   exp_c [`MM_DIAGS];

  matmul_top i_dut (
    .clk                     (clk),
    .reset                   (reset),
    .enable_writing_to_mem   (enable_writing_to_mem),
    .enable_reading_from_mem (enable_reading_from_mem),
    .data_pi                 (data_pi),
    .addr_pi                 (addr_pi),
    .we_a                    (we_a),
    .we_b                    (we_b),
    .data_from_out_mat       (data_from_out_mat),
    .start_mat_mul           (start_mat_mul),
    .done_mat_mul            (done_mat_mul)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog on total cycles
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    report_failure("simulation timed out");
  end

  task automatic report_failure(input string why);
    $display("TEST FAIL");
    $fatal(1, why);
  endtask

  task automatic check_row(input addr_t addr, input row_t got, input row_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: C row %0d read %h, expected %h", $time, addr, got, exp);
      report_failure("C row mismatch");
    end
  endtask

  task automatic check_done(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: done_mat_mul is %b %s, expected %b", $time, got, what, exp);
      report_failure("done_mat_mul mismatch");
    end
  endtask

  // narrow elements are 8 bit
  function automatic data_t pick_element(input logic wide);
    data_t v;
    v = data_t'($random(seed));
    if (!wide) begin
      v = v & 16'h00ff;
    end
    return v;
  endfunction

  // wide rows of A and wide columns of B push sums past 16 bits
  task automatic build_matrices(input logic full);
    logic a_wide [`MM_SIZE];
    logic b_wide [`MM_SIZE];
    int   r;
    for (int i = 0; i < `MM_SIZE; i++) begin
      r = $random(seed);
      a_wide[i] = full && r[0];
      b_wide[i] = full && r[1];
    end
    if (full) begin
      // at least one narrow and one wide line per side
      a_wide[0] = 1'b0;
      b_wide[0] = 1'b0;
      a_wide[`MM_SIZE-1] = 1'b1;
      b_wide[`MM_SIZE-1] = 1'b1;
    end
    for (int i = 0; i < `MM_SIZE; i++) begin
      for (int t = 0; t < `MM_SIZE; t++) begin
        a_mat[i][t] = pick_element(a_wide[i]);
        b_mat[i][t] = pick_element(b_wide[t]);
      end
    end
  endtask

  // reference product, wrapped sums, saturation, diagonal layout
  task automatic compute_expected();
    acc_t  sum;
    data_t c_sat [`MM_SIZE][`MM_SIZE];
    int    col;
    for (int i = 0; i < `MM_SIZE; i++) begin
      for (int j = 0; j < `MM_SIZE; j++) begin
        sum = '0;
        for (int t = 0; t < `MM_SIZE; t++) begin
          sum = sum + acc_t'(a_mat[i][t]) * acc_t'(b_mat[t][j]);
        end
        if (sum[2*`MM_DWIDTH-1:`MM_DWIDTH] != '0) begin
          c_sat[i][j] = 16'hffff;
          sat_seen++;
        end else begin
          c_sat[i][j] = sum[`MM_DWIDTH-1:0];
          exact_seen++;
        end
      end
    end
    for (int k = 0; k < `MM_DIAGS; k++) begin
      exp_c[k] = '0;
      for (int i = 0; i < `MM_SIZE; i++) begin
        col = k - i;
        if (col >= 0 && col < `MM_SIZE) begin
          exp_c[k][i*`MM_DWIDTH +: `MM_DWIDTH] = c_sat[i][col];
        end
      end
    end
  endtask

  // A by columns, then B by rows
  task automatic write_operands();
    row_t word;
    for (int t = 0; t < 2 * `MM_SIZE; t++) begin
      for (int l = 0; l < `MM_SIZE; l++) begin
        if (t < `MM_SIZE) begin
          word[l*`MM_DWIDTH +: `MM_DWIDTH] = a_mat[l][t];
        end else begin
          word[l*`MM_DWIDTH +: `MM_DWIDTH] = b_mat[t-`MM_SIZE][l];
        end
      end
      @(posedge clk);
      enable_writing_to_mem <= 1'b1;
      we_a    <= (t < `MM_SIZE);
      we_b    <= (t >= `MM_SIZE);
      addr_pi <= addr_t'(t % `MM_SIZE);
      data_pi <= word;
    end
    @(posedge clk);
    enable_writing_to_mem <= 1'b0;
    we_a <= 1'b0;
    we_b <= 1'b0;
  endtask

  task automatic run_engine();
    @(negedge clk);
    check_done(done_mat_mul, 1'b0, "before start");
    @(posedge clk);
    start_mat_mul <= 1'b1;
    // bounded by the watchdog
    @(negedge clk);
    while (!done_mat_mul) begin
      @(negedge clk);
    end
    for (int k = 0; k < HOLD_CYCLES; k++) begin
      @(negedge clk);
      check_done(done_mat_mul, 1'b1, "while start is held");
    end
    @(posedge clk);
    start_mat_mul <= 1'b0;
    @(negedge clk);
    check_done(done_mat_mul, 1'b1, "in the cycle start drops");
    @(negedge clk);
    check_done(done_mat_mul, 1'b0, "after start dropped");
  endtask

  // addresses back to back, data two cycles behind
  task automatic read_results();
    for (int n = 0; n < `MM_DIAGS + `MM_READ_LATENCY; n++) begin
      @(posedge clk);
      if (n < `MM_DIAGS) begin
        enable_reading_from_mem <= 1'b1;
        addr_pi <= addr_t'(n);
      end
      @(negedge clk);
      if (n >= `MM_READ_LATENCY) begin
        check_row(addr_t'(n - `MM_READ_LATENCY), data_from_out_mat,
                  exp_c[n - `MM_READ_LATENCY]);
      end
    end
    @(posedge clk);
    enable_reading_from_mem <= 1'b0;
  endtask

  initial begin
    reset <= 1'b1;
    enable_writing_to_mem   <= 1'b0;
    enable_reading_from_mem <= 1'b0;
    data_pi       <= '0;
    addr_pi       <= '0;
    we_a          <= 1'b0;
    we_b          <= 1'b0;
    start_mat_mul <= 1'b0;
    sat_seen   = 0;
    exact_seen = 0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    // idle, no run yet
    repeat (5) begin
      @(negedge clk);
      check_done(done_mat_mul, 1'b0, "in idle after reset");
    end
    // narrow and full range runs alternate, new operands every run
    for (int r = 0; r < RUNS; r++) begin
      build_matrices(r % 2 == 1);
      compute_expected();
      write_operands();
      run_engine();
      read_results();
    end
    if (sat_seen == 0 || exact_seen == 0) begin
      $display("saturation coverage missing: %0d saturated, %0d exact elements",
               sat_seen, exact_seen);
      report_failure("stimulus never produced both element kinds");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+.
matmul_pkg.sv
matrix_bank.sv
step_counter.sv
matmul_sequencer.sv
operand_skew.sv
processing_element.sv
systolic_array.sv
result_packer.sv
matmul_top.sv
tb_matmul.sv

// ==== Makefile ====
TOP := tb_matmul

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module matmul_top

clean:
	rm -rf obj_dir
